// ==== verilog/mips_macros.svh ====
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// Datapath and register file widths
`define MIPS_XLEN       32
`define MIPS_REG_AW     5
`define MIPS_NREGS      (1 << `MIPS_REG_AW)

// Word-addressed memories
`define MIPS_PM_AW      6
`define MIPS_DM_AW      6
`define MIPS_PM_DEPTH   (1 << `MIPS_PM_AW)
`define MIPS_DM_DEPTH   (1 << `MIPS_DM_AW)

// Opcodes, instr[31:26]
`define MIPS_OP_RTYPE   6'h00
`define MIPS_OP_BEQ     6'h04
`define MIPS_OP_ADDI    6'h08
`define MIPS_OP_LW      6'h23
`define MIPS_OP_SW      6'h2B

// R-type function codes, instr[5:0]
`define MIPS_FN_ADD     6'h20
`define MIPS_FN_SUB     6'h22
`define MIPS_FN_AND     6'h24
`define MIPS_FN_OR      6'h25
`define MIPS_FN_SLT     6'h2A

`endif

// ==== verilog/mips_pkg.sv ====
`include "mips_macros.svh"

package mips_pkg;

   typedef enum logic [2:0]
   {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_SLT = 3'd4
   } alu_op_e;

   // Decoded control, carried down the pipe
   typedef struct packed
   {
      logic    reg_write;
      logic    mem_to_reg;
      logic    mem_read;
      logic    mem_write;
      logic    alu_src;
      logic    reg_dst;
      alu_op_e alu_op;
   } ctrl_t;

   // Program load strobe
   typedef struct packed
   {
      logic                   valid;
      logic [`MIPS_PM_AW-1:0] addr;
      logic [`MIPS_XLEN-1:0]  data;
   } pm_write_t;

   ///////////////////////////////////////////////////////////////////////
   // Pipeline registers
   ///////////////////////////////////////////////////////////////////////

   typedef struct packed
   {
      logic                  valid;
      logic [`MIPS_XLEN-1:0] pc_plus1;
      logic [`MIPS_XLEN-1:0] instr;
   } if_id_t;

   typedef struct packed
   {
      logic                    valid;
      ctrl_t                   ctrl;
      logic [`MIPS_XLEN-1:0]   rdata1;
      logic [`MIPS_XLEN-1:0]   rdata2;
      logic [`MIPS_XLEN-1:0]   imm;
      logic [`MIPS_REG_AW-1:0] rs;
      logic [`MIPS_REG_AW-1:0] rt;
      logic [`MIPS_REG_AW-1:0] rd;
   } id_ex_t;

   typedef struct packed
   {
      logic                    valid;
      ctrl_t                   ctrl;
      logic [`MIPS_XLEN-1:0]   alu_result;
      logic [`MIPS_XLEN-1:0]   store_data;
      logic [`MIPS_REG_AW-1:0] dst;
   } ex_mem_t;

   // Also the retire stream; valid only for writes to a non-zero register
   typedef struct packed
   {
      logic                    valid;
      logic [`MIPS_REG_AW-1:0] dst;
      logic [`MIPS_XLEN-1:0]   data;
   } wb_t;

endpackage

// ==== verilog/fetch_stage.sv ====
`timescale 1ns/1ps
`include "mips_macros.svh"

module fetch_stage
(
   input  logic                   CLK,
   input  logic                   RESET,
   input  logic                   enable,
   input  mips_pkg::pm_write_t    pm_wr,
   input  logic                   stall,
   input  logic                   branch_taken,
   input  logic [`MIPS_PM_AW-1:0] branch_target,
   output mips_pkg::if_id_t       if_id
);
   import mips_pkg::*;

   logic [`MIPS_XLEN-1:0]  pm [`MIPS_PM_DEPTH];
   logic [`MIPS_PM_AW-1:0] pc;
   logic [`MIPS_XLEN-1:0]  pc_plus1;
   logic [`MIPS_XLEN-1:0]  instr;
   if_id_t                 if_id_next;

   // Load port, driven by the testbench while the pipe is frozen
   always_ff @(posedge CLK)
   begin
      if (pm_wr.valid)
      begin
         pm[pm_wr.addr] <= pm_wr.data;
      end
   end

   assign instr    = pm[pc];
   assign pc_plus1 = `MIPS_XLEN'(pc) + `MIPS_XLEN'(1);

   // Taken branch squashes the instruction fetched behind it
   always_comb
   begin
      if_id_next = '0;
      if (!branch_taken)
      begin
         if_id_next.valid    = 1'b1;
         if_id_next.pc_plus1 = pc_plus1;
         if_id_next.instr    = instr;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // PC and IF/ID
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK or posedge RESET)
   begin
      if (RESET)
      begin
         pc    <= '0;
         if_id <= '0;
      end
      else if (enable && !stall)
      begin
         pc    <= branch_taken ? branch_target : pc_plus1[`MIPS_PM_AW-1:0];
         if_id <= if_id_next;
      end
   end

endmodule

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ps
`include "mips_macros.svh"

module decode_stage
(
   input  logic                   CLK,
   input  logic                   RESET,
   input  logic                   enable,
   input  mips_pkg::if_id_t       if_id,
   input  mips_pkg::wb_t          wb,
   output logic                   stall,
   output logic                   branch_taken,
   output logic [`MIPS_PM_AW-1:0] branch_target,
   output mips_pkg::id_ex_t       id_ex
);
   import mips_pkg::*;

   logic [`MIPS_XLEN-1:0]   regs [`MIPS_NREGS];
   logic [5:0]              opcode;
   logic [5:0]              funct;
   logic [`MIPS_REG_AW-1:0] rs;
   logic [`MIPS_REG_AW-1:0] rt;
   logic [`MIPS_REG_AW-1:0] rd;
   logic [`MIPS_XLEN-1:0]   imm;
   logic [`MIPS_XLEN-1:0]   rdata1;
   logic [`MIPS_XLEN-1:0]   rdata2;
   ctrl_t                   ctrl;
   logic                    is_beq;
   id_ex_t                  id_ex_next;

   // Instruction fields
   assign opcode = if_id.instr[31:26];
   assign rs     = if_id.instr[25:21];
   assign rt     = if_id.instr[20:16];
   assign rd     = if_id.instr[15:11];
   assign funct  = if_id.instr[5:0];
   assign imm    = {{16{if_id.instr[15]}}, if_id.instr[15:0]};

   //////////////////////////////////////////////////////////////////////
   // Control decode
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      ctrl   = '0;
      is_beq = 1'b0;
      case (opcode)
         `MIPS_OP_RTYPE:
         begin
            ctrl.reg_write = 1'b1;
            ctrl.reg_dst   = 1'b1;
            case (funct)
               `MIPS_FN_ADD: ctrl.alu_op = ALU_ADD;
               `MIPS_FN_SUB: ctrl.alu_op = ALU_SUB;
               `MIPS_FN_AND: ctrl.alu_op = ALU_AND;
               `MIPS_FN_OR:  ctrl.alu_op = ALU_OR;
               `MIPS_FN_SLT: ctrl.alu_op = ALU_SLT;
               // Unsupported function, no write
               default:      ctrl = '0;
            endcase
         end
         `MIPS_OP_ADDI:
         begin
            ctrl.reg_write = 1'b1;
            ctrl.alu_src   = 1'b1;
         end
         `MIPS_OP_LW:
         begin
            ctrl.reg_write  = 1'b1;
            ctrl.mem_to_reg = 1'b1;
            ctrl.mem_read   = 1'b1;
            ctrl.alu_src    = 1'b1;
         end
         `MIPS_OP_SW:
         begin
            ctrl.mem_write = 1'b1;
            ctrl.alu_src   = 1'b1;
         end
         `MIPS_OP_BEQ: is_beq = 1'b1;
         default:      ctrl = '0;
      endcase
      // Bubbles decode to nothing
      if (!if_id.valid)
      begin
         ctrl   = '0;
         is_beq = 1'b0;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Register file
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK)
   begin
      if (enable && wb.valid)
      begin
         regs[wb.dst] <= wb.data;
      end
   end

   // Same-cycle write is bypassed to the read; r0 reads as zero
   assign rdata1 = (rs == '0)                   ? '0      :
                   (wb.valid && (wb.dst == rs)) ? wb.data : regs[rs];
   assign rdata2 = (rt == '0)                   ? '0      :
                   (wb.valid && (wb.dst == rt)) ? wb.data : regs[rt];

   // Load-use: the load sits in ID/EX, its consumer here
   assign stall = if_id.valid && id_ex.valid && id_ex.ctrl.mem_read &&
                  (id_ex.rt != '0) && ((id_ex.rt == rs) || (id_ex.rt == rt));

   // Branch resolved here, word-relative target
   assign branch_taken  = is_beq && (rdata1 == rdata2) && !stall;
   assign branch_target = if_id.pc_plus1[`MIPS_PM_AW-1:0] + imm[`MIPS_PM_AW-1:0];

   always_comb
   begin
      id_ex_next = '0;
      if (!stall)
      begin
         id_ex_next.valid  = if_id.valid;
         id_ex_next.ctrl   = ctrl;
         id_ex_next.rdata1 = rdata1;
         id_ex_next.rdata2 = rdata2;
         id_ex_next.imm    = imm;
         id_ex_next.rs     = rs;
         id_ex_next.rt     = rt;
         id_ex_next.rd     = rd;
      end
   end

   always_ff @(posedge CLK or posedge RESET)
   begin
      if (RESET)
      begin
         id_ex <= '0;
      end
      else if (enable)
      begin
         id_ex <= id_ex_next;
      end
   end

endmodule

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ps
`include "mips_macros.svh"

module execute_stage
(
   input  logic              CLK,
   input  logic              RESET,
   input  logic              enable,
   input  mips_pkg::id_ex_t  id_ex,
   input  mips_pkg::wb_t     wb,
   output mips_pkg::ex_mem_t ex_mem
);
   import mips_pkg::*;

   logic                    mem_fwd_ok;
   logic [`MIPS_XLEN-1:0]   op_a;
   logic [`MIPS_XLEN-1:0]   op_b;
   logic [`MIPS_XLEN-1:0]   alu_b;
   logic [`MIPS_XLEN-1:0]   alu_result;
   logic [`MIPS_REG_AW-1:0] dst;
   ex_mem_t                 ex_mem_next;

   //////////////////////////////////////////////////////////////////////
   // Forwarding, EX/MEM is newer than MEM/WB
   //////////////////////////////////////////////////////////////////////

   assign mem_fwd_ok = ex_mem.valid && ex_mem.ctrl.reg_write && (ex_mem.dst != '0);

   assign op_a = (mem_fwd_ok && (ex_mem.dst == id_ex.rs)) ? ex_mem.alu_result :
                 (wb.valid && (wb.dst == id_ex.rs))       ? wb.data           :
                                                            id_ex.rdata1;
   assign op_b = (mem_fwd_ok && (ex_mem.dst == id_ex.rt)) ? ex_mem.alu_result :
                 (wb.valid && (wb.dst == id_ex.rt))       ? wb.data           :
                                                            id_ex.rdata2;

   assign alu_b = id_ex.ctrl.alu_src ? id_ex.imm : op_b;
   assign dst   = id_ex.ctrl.reg_dst ? id_ex.rd : id_ex.rt;

   always_comb
   begin
      case (id_ex.ctrl.alu_op)
         ALU_ADD: alu_result = op_a + alu_b;
         ALU_SUB: alu_result = op_a - alu_b;
         ALU_AND: alu_result = op_a & alu_b;
         ALU_OR:  alu_result = op_a | alu_b;
         // Signed compare
         ALU_SLT: alu_result = {31'd0, $signed(op_a) < $signed(alu_b)};
         default: alu_result = '0;
      endcase
   end

   always_comb
   begin
      ex_mem_next.valid      = id_ex.valid;
      ex_mem_next.ctrl       = id_ex.ctrl;
      ex_mem_next.alu_result = alu_result;
      ex_mem_next.store_data = op_b;
      ex_mem_next.dst        = dst;
   end

   always_ff @(posedge CLK or posedge RESET)
   begin
      if (RESET)
      begin
         ex_mem <= '0;
      end
      else if (enable)
      begin
         ex_mem <= ex_mem_next;
      end
   end

endmodule

// ==== verilog/memory_stage.sv ====
`timescale 1ns/1ps
`include "mips_macros.svh"

module memory_stage
(
   input  logic              CLK,
   input  logic              RESET,
   input  logic              enable,
   input  mips_pkg::ex_mem_t ex_mem,
   output mips_pkg::wb_t     wb
);
   import mips_pkg::*;

   logic [`MIPS_XLEN-1:0]  dm [`MIPS_DM_DEPTH];
   logic [`MIPS_DM_AW-1:0] dm_addr;
   logic [`MIPS_XLEN-1:0]  load_data;
   wb_t                    wb_next;

   // Word index straight from the ALU result
   assign dm_addr   = ex_mem.alu_result[`MIPS_DM_AW-1:0];
   assign load_data = dm[dm_addr];

   always_ff @(posedge CLK)
   begin
      if (enable && ex_mem.valid && ex_mem.ctrl.mem_write)
      begin
         dm[dm_addr] <= ex_mem.store_data;
      end
   end

   // Writes to r0 never retire
   always_comb
   begin
      wb_next.valid = ex_mem.valid && ex_mem.ctrl.reg_write && (ex_mem.dst != '0);
      wb_next.dst   = ex_mem.dst;
      wb_next.data  = ex_mem.ctrl.mem_to_reg ? load_data : ex_mem.alu_result;
   end

   always_ff @(posedge CLK or posedge RESET)
   begin
      if (RESET)
      begin
         wb <= '0;
      end
      else if (enable)
      begin
         wb <= wb_next;
      end
   end

endmodule

// ==== verilog/mips_pipe.sv ====
`timescale 1ns/1ps
`include "mips_macros.svh"

module mips_pipe
(
   input  logic                CLK,
   input  logic                RESET,
   input  logic                enable,
   input  mips_pkg::pm_write_t pm_wr,
   output mips_pkg::wb_t       retire
);
   import mips_pkg::*;

   if_id_t                 if_id;
   id_ex_t                 id_ex;
   ex_mem_t                ex_mem;
   wb_t                    wb;
   logic                   stall;
   logic                   branch_taken;
   logic [`MIPS_PM_AW-1:0] branch_target;

   //////////////////////////////////////////////////////////////////////
   // Stages
   //////////////////////////////////////////////////////////////////////

   fetch_stage fetch_stage_i
   (
      .CLK           (CLK),
      .RESET         (RESET),
      .enable        (enable),
      .pm_wr         (pm_wr),
      .stall         (stall),
      .branch_taken  (branch_taken),
      .branch_target (branch_target),
      .if_id         (if_id)
   );

   decode_stage decode_stage_i
   (
      .CLK           (CLK),
      .RESET         (RESET),
      .enable        (enable),
      .if_id         (if_id),
      .wb            (wb),
      .stall         (stall),
      .branch_taken  (branch_taken),
      .branch_target (branch_target),
      .id_ex         (id_ex)
   );

   execute_stage execute_stage_i
   (
      .CLK    (CLK),
      .RESET  (RESET),
      .enable (enable),
      .id_ex  (id_ex),
      .wb     (wb),
      .ex_mem (ex_mem)
   );

   memory_stage memory_stage_i
   (
      .CLK    (CLK),
      .RESET  (RESET),
      .enable (enable),
      .ex_mem (ex_mem),
      .wb     (wb)
   );

   assign retire = wb;

endmodule

// ==== dv/mips_pipe_chk.sv ====
`timescale 1ns/1ps

module mips_pipe_chk
(
   input logic             CLK,
   input logic             RESET,
   input logic             enable,
   input logic             stall,
   input logic             branch_taken,
   input mips_pkg::id_ex_t id_ex,
   input mips_pkg::wb_t    wb
);

   // Read by the testbench
   int unsigned fail_count = 0;

   // Decode is quiet while the pipe is held in reset
   reset_quiet: assert property (@(posedge CLK) RESET |-> !stall && !branch_taken)
   else
   begin
      fail_count++;
      $error("stall or branch_taken high during reset");
   end

   // Load-use bubble
   stall_bubble: assert property (@(posedge CLK) disable iff (RESET)
      enable && stall |=> id_ex.ctrl == '0)
   else
   begin
      fail_count++;
      $error("id_ex.ctrl not cleared after a stall");
   end

   frozen_no_retire: assert property (@(posedge CLK) disable iff (RESET)
      !enable |-> !wb.valid)
   else
   begin
      fail_count++;
      $error("write-back valid while the pipe is frozen");
   end

endmodule

// ==== dv/mips_pipe_prog.svh ====
`ifndef MIPS_PIPE_PROG_SVH
`define MIPS_PIPE_PROG_SVH

// Expected write-back, register then value
typedef struct packed
{
   logic [4:0]  dst;
   logic [31:0] data;
} wb_expect_t;

localparam int NUM_PROGS = 4;
localparam int MAX_INSTR = 12;
localparam int MAX_WB    = 10;

// Instruction words, each program ends in beq r0, r0, -1
localparam logic [31:0] PROG_CODE [NUM_PROGS][MAX_INSTR] = '{
   // Arithmetic without hazards, addi to r0, then a read of r0
   '{32'h20010005, 32'h2002000C, 32'h2003FFFD, 32'h20000007,
     32'h00015020, 32'h00222020, 32'h00222822, 32'h00433024,
     32'h00223825, 32'h0061402A, 32'h0023482A, 32'h1000FFFF},
   // Back-to-back dependencies through EX/MEM and MEM/WB
   '{32'h20010003, 32'h20220004, 32'h00221820, 32'h00612022,
     32'h00642824, 32'h00A4302A, 32'h00C33825, 32'h20210001,
     32'h20210001, 32'h20210001, 32'h1000FFFF, 32'h00000000},
   // sw then lw, each load followed at once by its consumer
   '{32'h20010014, 32'h20021234, 32'hAC220004, 32'h8C230004,
     32'h00612020, 32'hAC040000, 32'h8C050000, 32'h00453022,
     32'h1000FFFF, 32'h00000000, 32'h00000000, 32'h00000000},
   // Taken beq skips addi r5, untaken beq falls through
   '{32'h20010009, 32'h20020009, 32'h20030004, 32'h200A0001,
     32'h10220001, 32'h20050063, 32'h20060006, 32'h10230002,
     32'h20070007, 32'h20080008, 32'h1000FFFF, 32'h00000000}
};

localparam int PROG_LEN [NUM_PROGS] = '{12, 11, 9, 11};
localparam int EXP_LEN  [NUM_PROGS] = '{10, 10, 6, 7};

// Write-backs in retire order
localparam wb_expect_t EXP_WB [NUM_PROGS][MAX_WB] = '{
   '{{5'd1, 32'h00000005}, {5'd2, 32'h0000000C}, {5'd3, 32'hFFFFFFFD},
     {5'd10, 32'h00000005}, {5'd4, 32'h00000011}, {5'd5, 32'hFFFFFFF9},
     {5'd6, 32'h0000000C}, {5'd7, 32'h0000000D}, {5'd8, 32'h00000001},
     {5'd9, 32'h00000000}},
   '{{5'd1, 32'h00000003}, {5'd2, 32'h00000007}, {5'd3, 32'h0000000A},
     {5'd4, 32'h00000007}, {5'd5, 32'h00000002}, {5'd6, 32'h00000001},
     {5'd7, 32'h0000000B}, {5'd1, 32'h00000004}, {5'd1, 32'h00000005},
     {5'd1, 32'h00000006}},
   '{{5'd1, 32'h00000014}, {5'd2, 32'h00001234}, {5'd3, 32'h00001234},
     {5'd4, 32'h00001248}, {5'd5, 32'h00001248}, {5'd6, 32'hFFFFFFEC},
     '0, '0, '0, '0},
   '{{5'd1, 32'h00000009}, {5'd2, 32'h00000009}, {5'd3, 32'h00000004},
     {5'd10, 32'h00000001}, {5'd6, 32'h00000006}, {5'd7, 32'h00000007},
     {5'd8, 32'h00000008}, '0, '0, '0}
};

`endif

// ==== dv/mips_pipe_tb.sv ====
`timescale 1ns/1ps
`include "mips_macros.svh"

module mips_pipe_tb;
   import mips_pkg::*;

   `include "mips_pipe_prog.svh"

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 10;
   localparam int IDLE_CYCLES  = 4;
   localparam int DRAIN_CYCLES = 20;
   localparam int NUM_RUNS     = NUM_PROGS + 1;

   // Program 0 again at the end, after a fresh reset and reload
   localparam int RUN_ORDER [NUM_RUNS] = '{0, 1, 2, 3, 0};

   logic      CLK;
   logic      RESET;
   logic      enable;
   pm_write_t pm_wr;
   wb_t       retire;

   mips_pipe mips_pipe_i
   (
      .CLK    (CLK),
      .RESET  (RESET),
      .enable (enable),
      .pm_wr  (pm_wr),
      .retire (retire)
   );

   bind decode_stage mips_pipe_chk pipe_chk_i
   (
      .CLK          (CLK),
      .RESET        (RESET),
      .enable       (enable),
      .stall        (stall),
      .branch_taken (branch_taken),
      .id_ex        (id_ex),
      .wb           (wb)
   );

   initial
   begin
      CLK = 1'b0;
      forever #(CLK_PERIOD / 2) CLK = ~CLK;
   end

   //////////////////////////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////////////////////////

   task automatic stop_on_failure(input string what);
      $display("%s", what);
      $display("*** TEST FAILED ***");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected)
      begin
         stop_on_failure($sformatf("FAILED at %0t: %s is 0x%08h, expected 0x%08h",
                                   $time, name, actual, expected));
      end
   endtask

   // Reset and freeze, nothing may retire meanwhile
   task automatic reset_dut();
      @(negedge CLK);
      RESET  = 1'b1;
      enable = 1'b0;
      pm_wr  = '0;
      repeat (RESET_CYCLES)
      begin
         @(negedge CLK);
         check_value("retire.valid", 32'(retire.valid), 32'd0);
      end
      RESET = 1'b0;
   endtask

   task automatic load_program(input int p);
      for (int i = 0; i < PROG_LEN[p]; i++)
      begin
         pm_wr.valid = 1'b1;
         pm_wr.addr  = `MIPS_PM_AW'(i);
         pm_wr.data  = PROG_CODE[p][i];
         @(negedge CLK);
         check_value("retire.valid", 32'(retire.valid), 32'd0);
      end
      pm_wr = '0;
      repeat (IDLE_CYCLES)
      begin
         @(negedge CLK);
         check_value("retire.valid", 32'(retire.valid), 32'd0);
      end
   endtask

   task automatic run_program(input int p);
      int count;
      reset_dut();
      load_program(p);
      enable = 1'b1;
      count  = 0;
      // Each retire event against the next table entry
      while (count < EXP_LEN[p])
      begin
         @(negedge CLK);
         if (retire.valid)
         begin
            check_value($sformatf("retire.dst (program %0d, entry %0d)", p, count),
                        32'(retire.dst), 32'(EXP_WB[p][count].dst));
            check_value($sformatf("retire.data (program %0d, entry %0d)", p, count),
                        retire.data, EXP_WB[p][count].data);
            count++;
         end
      end
      // Only the beq loop is left, so the stream must stay empty
      repeat (DRAIN_CYCLES)
      begin
         @(negedge CLK);
         if (retire.valid)
         begin
            stop_on_failure($sformatf("Program %0d wrote r%0d = 0x%08h after its last %s",
                                      p, retire.dst, retire.data, "expected write-back"));
         end
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Watchdog and main sequence
   //////////////////////////////////////////////////////////////////////

   initial
   begin : watchdog
      int limit_cycles;
      limit_cycles = 50;
      for (int r = 0; r < NUM_RUNS; r++)
      begin
         limit_cycles += RESET_CYCLES + PROG_LEN[RUN_ORDER[r]] + IDLE_CYCLES + 2;
         limit_cycles += 20 * EXP_LEN[RUN_ORDER[r]] + DRAIN_CYCLES;
      end
      #(limit_cycles * CLK_PERIOD);
      stop_on_failure($sformatf("Timeout, the run did not end within %0d cycles",
                                limit_cycles));
   end

   // Any bound assertion failure ends the run at once
   initial
   begin
      wait (mips_pipe_i.decode_stage_i.pipe_chk_i.fail_count != 0);
      stop_on_failure("A pipeline assertion failed, see the error above");
   end

   initial
   begin
      RESET  = 1'b1;
      enable = 1'b0;
      pm_wr  = '0;
      for (int r = 0; r < NUM_RUNS; r++)
      begin
         run_program(RUN_ORDER[r]);
      end
      if (mips_pipe_i.decode_stage_i.pipe_chk_i.fail_count == 0)
      begin
         $display("*** TEST PASSED ***");
         $finish;
      end
      else
      begin
         stop_on_failure($sformatf("%0d pipeline assertion failures during the run",
                                   mips_pipe_i.decode_stage_i.pipe_chk_i.fail_count));
      end
   end

endmodule

// ==== mips_pipe.f ====
+incdir+verilog
+incdir+dv
verilog/mips_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/mips_pipe.sv
dv/mips_pipe_chk.sv
dv/mips_pipe_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --top-module mips_pipe_tb \
   -f mips_pipe.f --Mdir "$OBJ" -o mips_pipe_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

# Assertion errors are counted by the checker, so let the run continue past them
"./$OBJ/mips_pipe_sim" +verilator+error+limit+100 > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -qF '*** TEST FAILED ***' "$LOG"; then
   echo "Simulation reported a failure"
   exit 1
fi
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi
exit 0
